// ==== Makefile ====
TOP = tb_dwconv

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// ==== files.f ====
verilog/dwconv_pkg.sv
verilog/dwconv_ctrl.sv
verilog/tap_counter.sv
verilog/coef_regs.sv
verilog/fmap_buffer.sv
verilog/mac_unit.sv
verilog/act_store.sv
verilog/dwconv_top.sv
tb/tb_dwconv.sv

// ==== tb/tb_dwconv.sv ====
`timescale 1ns/10ps

module tb_dwconv import dwconv_pkg::*; ();

	// 7 frames and about 2200 bus accesses, with margin.
	localparam int WB_ACCESSES = 2560;
	localparam int WD_CYCLES = 10 * 300 + WB_ACCESSES * 4;

	logic clk;
	logic rstn;
	logic valid;
	frame_t input_act;
	logic ready;
	out_vec_t output_act;
	logic out_valid;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_adr_t wb_adr;
	sample_t wb_dat_i;
	sample_t wb_dat_o;
	logic wb_ack;

	// coefficients as the host last wrote them.
	sample_t w_ref [NUM_CH][NUM_TAPS];
	sample_t b_ref [NUM_CH];
	out_vec_t last_out;
	logic [31:0] lfsr;

	dwconv_top u_dwconv_top (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// **********************************************************************
	// helpers.
	// **********************************************************************
	task automatic compare_value(input string name, input logic [OUT_W-1:0] exp,
			input logic [OUT_W-1:0] got);
		if (got !== exp) begin
			$display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic wb_access(input logic we, input int adr, input sample_t dat,
			output sample_t rdata);
		@(posedge clk);
		#5;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = wb_adr_t'(adr);
		wb_dat_i = dat;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		rdata = wb_dat_o;
		#4;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// a second ack would show up here.
		@(posedge clk);
		#1;
		compare_value("wb_ack", 0, wb_ack);
	endtask

	task automatic write_coef(input int c, input int slot, input sample_t val);
		sample_t rd;
		wb_access(1'b1, c * 16 + slot, val, rd);
		if (slot < NUM_TAPS)
			w_ref[c][slot] = val;
		else if (slot == BIAS_TAP)
			b_ref[c] = val;
	endtask

	task automatic read_expect(input int adr, input sample_t exp);
		sample_t rd;
		wb_access(1'b0, adr, '0, rd);
		compare_value($sformatf("wb_dat_o[adr %0h]", adr), exp, rd);
	endtask

	task automatic set_channel(input int c, input sample_t w, input sample_t b);
		for (int t = 0; t < NUM_TAPS; t++)
			write_coef(c, t, w);
		write_coef(c, BIAS_TAP, b);
	endtask

	// nine products plus bias, then relu6 on the Q15 sum.
	function automatic sample_t expected_channel(input frame_t f, input int c);
		acc_t sum;
		acc_t s;
		sum = acc_t'(b_ref[c]);
		for (int t = 0; t < NUM_TAPS; t++)
			sum = sum + acc_t'(sample_t'(f[(c * NUM_TAPS + t) * DATA_W +: DATA_W]))
				* acc_t'(w_ref[c][t]);
		if (sum < 0)
			return '0;
		s = sum >>> FRAC_BITS;
		if (s > RELU_MAX)
			return sample_t'(RELU_MAX);
		return sample_t'(s);
	endfunction

	task automatic check_frame(input frame_t f, input out_vec_t res);
		for (int c = 0; c < NUM_CH; c++)
			compare_value($sformatf("output_act[%0d]", c), expected_channel(f, c),
				res[c * DATA_W +: DATA_W]);
	endtask

	task automatic drive_frame(input frame_t f);
		@(posedge clk);
		#5;
		compare_value("ready", 1, ready);
		input_act = f;
		valid = 1'b1;
		@(posedge clk);
		#5;
		valid = 1'b0;
	endtask

	// poke raises valid with another frame for a few busy cycles, which must be ignored.
	task automatic wait_result(input logic poke, output out_vec_t res);
		int n;
		n = 0;
		forever begin
			@(posedge clk);
			#1;
			if (out_valid)
				break;
			compare_value("ready", 0, ready);
			compare_value("output_act", last_out, output_act);
			n++;
			if (poke) begin
				#4;
				valid = (n >= 10 && n < 13);
				if (n == 10)
					input_act = ~input_act;
			end
		end
		@(posedge clk);
		#1;
		compare_value("out_valid", 0, out_valid);
		res = output_act;
		last_out = res;
	endtask

	// **********************************************************************
	// directed tests.
	// **********************************************************************
	task automatic check_reset_state();
		int slot;
		compare_value("ready", 1, ready);
		compare_value("out_valid", 0, out_valid);
		compare_value("output_act", 0, output_act);
		for (int a = 0; a < 512; a++)
			read_expect(a, '0);
		for (int c = 0; c < NUM_CH; c++) begin
			slot = 10 + c % 6;
			write_coef(c, slot, sample_t'(rand_bits(16)));
			read_expect(c * 16 + slot, '0);
		end
	endtask

	task automatic readback_coefs();
		for (int c = 0; c < NUM_CH; c++)
			for (int s = 0; s <= BIAS_TAP; s++)
				write_coef(c, s, sample_t'(rand_bits(16)));
		for (int c = 0; c < NUM_CH; c++)
			for (int s = 0; s <= BIAS_TAP; s++)
				read_expect(c * 16 + s, (s < NUM_TAPS) ? w_ref[c][s] : b_ref[c]);
	endtask

	// weight k with activations near 4096 lands in 1 to 5.
	task automatic mid_range_frame();
		frame_t f;
		out_vec_t res;
		for (int c = 0; c < NUM_CH; c++) begin
			set_channel(c, sample_t'(1 + c % 5), sample_t'(c));
			for (int t = 0; t < NUM_TAPS; t++)
				f[(c * NUM_TAPS + t) * DATA_W +: DATA_W] = sample_t'(4096 + rand_bits(6));
		end
		drive_frame(f);
		wait_result(1'b0, res);
		check_frame(f, res);
	endtask

	task automatic clamp_limits();
		frame_t f;
		out_vec_t res;
		for (int c = 0; c < NUM_CH; c++) begin
			if (c % 2 == 0)
				set_channel(c, sample_t'(-1000), sample_t'(-5));
			else
				set_channel(c, sample_t'(8000), '0);
			for (int t = 0; t < NUM_TAPS; t++)
				f[(c * NUM_TAPS + t) * DATA_W +: DATA_W] =
					(c % 2 == 0) ? sample_t'(1000 + rand_bits(6)) : sample_t'(8000);
		end
		drive_frame(f);
		wait_result(1'b0, res);
		check_frame(f, res);
	endtask

	task automatic random_frames();
		frame_t f;
		out_vec_t res;
		logic [31:0] r;
		for (int c = 0; c < NUM_CH; c++) begin
			for (int t = 0; t < NUM_TAPS; t++) begin
				r = rand_bits(5);
				write_coef(c, t, sample_t'($signed(r[4:0])));
			end
			write_coef(c, BIAS_TAP, sample_t'(rand_bits(16)));
		end
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < NUM_CH * NUM_TAPS; i++)
				f[i * DATA_W +: DATA_W] = sample_t'(rand_bits(16));
			drive_frame(f);
			wait_result(k == 1, res);
			check_frame(f, res);
		end
	endtask

	task automatic stalled_coef_write();
		frame_t f;
		out_vec_t res;
		logic seen;
		logic got;
		set_channel(0, sample_t'(1), '0);
		for (int i = 0; i < NUM_CH * NUM_TAPS; i++)
			f[i * DATA_W +: DATA_W] = sample_t'(4096);
		drive_frame(f);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = '0;
		wb_dat_i = sample_t'(20000);
		seen = 1'b0;
		got = 1'b0;
		do begin
			@(posedge clk);
			#1;
			if (!seen)
				compare_value("wb_ack before out_valid", 0, wb_ack);
			if (seen && !got) begin
				res = output_act;
				got = 1'b1;
			end
			if (out_valid)
				seen = 1'b1;
		end while (!wb_ack);
		#4;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// the frame in flight still used the old weight.
		check_frame(f, res);
		last_out = res;
		w_ref[0][0] = sample_t'(20000);
		@(posedge clk);
		#1;
		compare_value("wb_ack", 0, wb_ack);
		drive_frame(f);
		wait_result(1'b0, res);
		check_frame(f, res);
	endtask

	initial begin
		#(WD_CYCLES * 100);
		$display("timeout, the testbench did not finish in the expected time");
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	initial begin
		lfsr = 32'd79904;
		rstn = 1'b0;
		valid = 1'b0;
		input_act = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		last_out = '0;
		repeat (2) @(posedge clk);
		#5;
		rstn = 1'b1;
		check_reset_state();
		readback_coefs();
		mid_range_frame();
		clamp_limits();
		random_frames();
		stalled_coef_write();
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== verilog/act_store.sv ====
`timescale 1ns/10ps

module act_store import dwconv_pkg::*; (
	input  logic     clk,
	input  logic     rstn,
	input  logic     start,
	input  logic     ch_result_valid,
	input  acc_t     ch_result,
	input  logic     out_valid,
	output out_vec_t output_act
);

	acc_t shifted;
	sample_t clamped;
	ch_idx_t ptr;
	out_vec_t shadow;

	// relu6 on the fixed point sum.
	always_comb begin
		shifted = ch_result >>> FRAC_BITS;
		if (ch_result < 0)
			clamped = '0;
		else if (shifted > RELU_MAX)
			clamped = sample_t'(RELU_MAX);
		else
			clamped = sample_t'(shifted);
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ptr <= '0;
			output_act <= '0;
		end else begin
			if (start)
				ptr <= '0;
			else if (ch_result_valid)
				ptr <= ptr + ch_idx_t'(1);
			if (out_valid)
				output_act <= shadow;
		end
	end

	always_ff @(posedge clk) begin
		if (ch_result_valid)
			shadow[int'(ptr) * DATA_W +: DATA_W] <= clamped;
	end

endmodule

// ==== verilog/coef_regs.sv ====
`timescale 1ns/10ps

module coef_regs import dwconv_pkg::*; (
	input  logic     clk,
	input  logic     rstn,
	input  logic     busy,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  sample_t  wb_dat_i,
	output sample_t  wb_dat_o,
	output logic     wb_ack,
	input  ch_idx_t  ch_idx,
	input  tap_idx_t tap_idx,
	output sample_t  weight,
	output sample_t  bias
);

	sample_t w_mem [NUM_CH][NUM_TAPS];
	sample_t b_mem [NUM_CH];
	ch_idx_t wb_ch;
	tap_idx_t wb_slot;
	logic wb_req;
	logic wb_go;
	sample_t rd_data;

	assign wb_ch = wb_adr[WB_ADR_W-1:$bits(tap_idx_t)];
	assign wb_slot = wb_adr[$bits(tap_idx_t)-1:0];
	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	// writes wait for idle so a running frame keeps its coefficients.
	assign wb_go = wb_req && (!wb_we || !busy);

	always_comb begin
		if (wb_slot < tap_idx_t'(NUM_TAPS))
			rd_data = w_mem[wb_ch][wb_slot];
		else if (wb_slot == tap_idx_t'(BIAS_TAP))
			rd_data = b_mem[wb_ch];
		else
			rd_data = '0;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wb_ack <= 1'b0;
			for (int c = 0; c < NUM_CH; c++) begin
				b_mem[c] <= '0;
				for (int t = 0; t < NUM_TAPS; t++)
					w_mem[c][t] <= '0;
			end
		end else begin
			wb_ack <= wb_go;
			if (wb_go && wb_we) begin
				if (wb_slot < tap_idx_t'(NUM_TAPS))
					w_mem[wb_ch][wb_slot] <= wb_dat_i;
				else if (wb_slot == tap_idx_t'(BIAS_TAP))
					b_mem[wb_ch] <= wb_dat_i;
			end
		end
	end

	// bus read data and the datapath read port.
	always_ff @(posedge clk) begin
		if (wb_go)
			wb_dat_o <= rd_data;
		weight <= w_mem[ch_idx][tap_idx];
		bias <= b_mem[ch_idx];
	end

endmodule

// ==== verilog/dwconv_ctrl.sv ====
`timescale 1ns/10ps

module dwconv_ctrl import dwconv_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  logic valid,
	input  logic last_tap,
	input  logic last_ch,
	output logic ready,
	output logic start,
	output logic step_en,
	output logic acc_clear,
	output logic busy,
	output logic out_valid
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic [1:0] drain_cnt;
	logic first_tap;

	assign ready = (state == ST_IDLE);
	assign busy = !ready;
	assign start = ready && valid;
	assign step_en = (state == ST_RUN);
	assign acc_clear = step_en && first_tap;
	assign out_valid = (state == ST_DONE);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:  if (valid) state_nxt = ST_RUN;
			ST_RUN:   if (last_tap && last_ch) state_nxt = ST_DRAIN;
			ST_DRAIN: if (drain_cnt == 2'(DRAIN_CYCLES - 1)) state_nxt = ST_DONE;
			ST_DONE:  state_nxt = ST_IDLE;
			default:  state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= ST_IDLE;
			drain_cnt <= '0;
			first_tap <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == ST_DRAIN)
				drain_cnt <= drain_cnt + 2'd1;
			else
				drain_cnt <= '0;
			// the step after a last tap opens a new channel.
			if (start)
				first_tap <= 1'b1;
			else if (step_en)
				first_tap <= last_tap;
		end
	end

endmodule

// ==== verilog/dwconv_pkg.sv ====
package dwconv_pkg;

	// **********************************************************************
	// layer geometry and number formats.
	// **********************************************************************
	localparam int NUM_CH = 32;
	localparam int NUM_TAPS = 9;
	localparam int DATA_W = 16;
	localparam int ACC_W = 32;
	localparam int FRAC_BITS = 15;
	localparam int RELU_MAX = 6;
	localparam int FRAME_W = NUM_CH * NUM_TAPS * DATA_W;
	localparam int OUT_W = NUM_CH * DATA_W;

	// word address is channel * 16 + slot.
	localparam int WB_ADR_W = 9;
	localparam int BIAS_TAP = 9;

	// read stage, accumulate stage and result store.
	localparam int DRAIN_CYCLES = 3;

	typedef logic signed [DATA_W-1:0] sample_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [FRAME_W-1:0] frame_t;
	typedef logic [OUT_W-1:0] out_vec_t;
	typedef logic [$clog2(NUM_CH)-1:0] ch_idx_t;
	typedef logic [3:0] tap_idx_t;
	typedef logic [WB_ADR_W-1:0] wb_adr_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DRAIN,
		ST_DONE
	} ctrl_state_t;

endpackage

// ==== verilog/dwconv_top.sv ====
`timescale 1ns/10ps

module dwconv_top import dwconv_pkg::*; (
	input  logic     clk,
	input  logic     rstn,
	input  logic     valid,
	input  frame_t   input_act,
	output logic     ready,
	output out_vec_t output_act,
	output logic     out_valid,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  sample_t  wb_dat_i,
	output sample_t  wb_dat_o,
	output logic     wb_ack
);

	logic start;
	logic step_en;
	logic acc_clear;
	logic busy;
	logic last_tap;
	logic last_ch;
	ch_idx_t ch_idx;
	tap_idx_t tap_idx;
	sample_t act;
	sample_t weight;
	sample_t bias;
	acc_t ch_result;
	logic ch_result_valid;

	dwconv_ctrl u_ctrl (
		.clk       (clk),
		.rstn      (rstn),
		.valid     (valid),
		.last_tap  (last_tap),
		.last_ch   (last_ch),
		.ready     (ready),
		.start     (start),
		.step_en   (step_en),
		.acc_clear (acc_clear),
		.busy      (busy),
		.out_valid (out_valid)
	);

	tap_counter u_tap_counter (
		.clk      (clk),
		.rstn     (rstn),
		.start    (start),
		.step_en  (step_en),
		.ch_idx   (ch_idx),
		.tap_idx  (tap_idx),
		.last_tap (last_tap),
		.last_ch  (last_ch)
	);

	coef_regs u_coef_regs (
		.clk      (clk),
		.rstn     (rstn),
		.busy     (busy),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.ch_idx   (ch_idx),
		.tap_idx  (tap_idx),
		.weight   (weight),
		.bias     (bias)
	);

	fmap_buffer u_fmap_buffer (
		.clk       (clk),
		.rstn      (rstn),
		.start     (start),
		.input_act (input_act),
		.ch_idx    (ch_idx),
		.tap_idx   (tap_idx),
		.act       (act)
	);

	mac_unit u_mac_unit (
		.clk             (clk),
		.rstn            (rstn),
		.acc_clear       (acc_clear),
		.step_en         (step_en),
		.act             (act),
		.weight          (weight),
		.bias            (bias),
		.ch_result       (ch_result),
		.ch_result_valid (ch_result_valid)
	);

	act_store u_act_store (
		.clk             (clk),
		.rstn            (rstn),
		.start           (start),
		.ch_result_valid (ch_result_valid),
		.ch_result       (ch_result),
		.out_valid       (out_valid),
		.output_act      (output_act)
	);

endmodule

// ==== verilog/fmap_buffer.sv ====
`timescale 1ns/10ps

module fmap_buffer import dwconv_pkg::*; (
	input  logic     clk,
	input  logic     rstn,
	input  logic     start,
	input  frame_t   input_act,
	input  ch_idx_t  ch_idx,
	input  tap_idx_t tap_idx,
	output sample_t  act
);

	frame_t frame_q;

	always_ff @(posedge clk) begin
		if (start)
			frame_q <= input_act;
	end

	// channel c, tap t sits at bit (c * 9 + t) * 16.
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			act <= '0;
		else
			act <= frame_q[(int'(ch_idx) * NUM_TAPS + int'(tap_idx)) * DATA_W +: DATA_W];
	end

endmodule

// ==== verilog/mac_unit.sv ====
`timescale 1ns/10ps

module mac_unit import dwconv_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  logic    acc_clear,
	input  logic    step_en,
	input  sample_t act,
	input  sample_t weight,
	input  sample_t bias,
	output acc_t    ch_result,
	output logic    ch_result_valid
);

	logic step_q;
	logic clr_q;
	tap_idx_t tap_cnt;
	tap_idx_t tap_pos;
	acc_t prod;
	acc_t acc;
	acc_t acc_nxt;

	// strobes delayed to meet the registered operand reads.
	assign tap_pos = clr_q ? '0 : tap_cnt;
	assign prod = act * weight;
	assign acc_nxt = (clr_q ? acc_t'(0) : acc) + prod;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			step_q <= 1'b0;
			clr_q <= 1'b0;
			tap_cnt <= '0;
			ch_result_valid <= 1'b0;
		end else begin
			step_q <= step_en;
			clr_q <= acc_clear;
			if (step_q)
				tap_cnt <= tap_pos + tap_idx_t'(1);
			ch_result_valid <= step_q && (tap_pos == tap_idx_t'(NUM_TAPS - 1));
		end
	end

	// sum wraps at 32 bits.
	always_ff @(posedge clk) begin
		if (step_q) begin
			acc <= acc_nxt;
			if (tap_pos == tap_idx_t'(NUM_TAPS - 1))
				ch_result <= acc_nxt + acc_t'(bias);
		end
	end

endmodule

// ==== verilog/tap_counter.sv ====
`timescale 1ns/10ps

module tap_counter import dwconv_pkg::*; (
	input  logic     clk,
	input  logic     rstn,
	input  logic     start,
	input  logic     step_en,
	output ch_idx_t  ch_idx,
	output tap_idx_t tap_idx,
	output logic     last_tap,
	output logic     last_ch
);

	assign last_tap = (tap_idx == tap_idx_t'(NUM_TAPS - 1));
	assign last_ch = (ch_idx == ch_idx_t'(NUM_CH - 1));

	// taps run fastest, channels advance on each tap wrap.
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ch_idx <= '0;
			tap_idx <= '0;
		end else if (start) begin
			ch_idx <= '0;
			tap_idx <= '0;
		end else if (step_en) begin
			if (last_tap) begin
				tap_idx <= '0;
				ch_idx <= ch_idx + ch_idx_t'(1);
			end else begin
				tap_idx <= tap_idx + tap_idx_t'(1);
			end
		end
	end

endmodule
